// ==== vlog.f ====
logic/board_bus_pkg.sv
logic/board_cmd_if.sv
logic/command_registers.sv
logic/board_bus_sequencer.sv
logic/board_bus_top.sv
verification/board_bus_properties.sv
verification/board_bus_checker.sv
verification/board_bus_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module board_bus_tb -Mdir obj_dir -f vlog.f
	./obj_dir/Vboard_bus_tb | tee sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verification/board_bus_tb.sv ====
`timescale 1ns/1ps

module board_bus_tb;
    import board_bus_pkg::*;

    localparam int ROWS            = 10;
    localparam int WATCHDOG_CYCLES = 2 * (ROWS * 4 * 40) + 20;

    logic        clock = 1'b0;
    logic        rst;
    logic        start;
    bus_opcode_t opcode;
    logic [2:0]  address;
    logic [31:0] param_word;
    logic        busy;
    logic        done;
    logic [31:0] response_word;
    logic [2:0]  response_count;
    logic [3:0]  board_select;
    logic [2:0]  bus_address;
    logic        test_address;
    logic        rd_n;
    logic        wr_n;
    logic [7:0]  data_out;
    logic        data_dir;
    logic [7:0]  data_in;
    logic [2:0]  expected_count;
    logic        run_over;
    int          error_count;
    int          done_count;
    int          assertion_failures;
    integer      seed = 32'hd5b5_2258;

    // Stimulus table with the expected response count per row
    bus_opcode_t tab_op[$];
    logic [2:0]  tab_addr[$];
    logic [31:0] tab_param[$];
    logic [2:0]  tab_count[$];
    logic        tab_twice[$];

    // Backplane boards
    logic [7:0] board_reg [4] = '{8'h00, 8'h00, 8'h00, 8'h00};
    logic [1:0] sel_index;
    logic       prev_wr_n = 1'b1;
    logic       prev_rd_n = 1'b1;

    always #50 clock = ~clock;

    board_bus_top #(.CLOCK_FREQUENCY(10_000_000), .SETTLE_NS(750)) board_bus_top_inst
    (
        .clock(clock), .rst(rst), .start(start), .opcode(opcode), .address(address),
        .param_word(param_word), .busy(busy), .done(done), .response_word(response_word),
        .response_count(response_count), .board_select(board_select),
        .bus_address(bus_address), .test_address(test_address), .rd_n(rd_n), .wr_n(wr_n),
        .data_out(data_out), .data_dir(data_dir), .data_in(data_in)
    );

    board_bus_checker #(.COMMANDS(ROWS)) response_check
    (
        .clock(clock), .rst(rst), .start(start), .opcode(opcode), .address(address),
        .param_word(param_word), .busy(busy), .done(done), .response_word(response_word),
        .response_count(response_count), .board_select(board_select),
        .bus_address(bus_address), .test_address(test_address), .rd_n(rd_n), .wr_n(wr_n),
        .data_out(data_out), .data_dir(data_dir), .expected_count(expected_count),
        .run_over(run_over), .error_count(error_count), .done_count(done_count)
    );

    bind board_bus_sequencer board_bus_properties bus_rules
    (
        .clock(clock), .rst(rst), .state(state), .board_select(board_select),
        .test_address(test_address), .rd_n(rd_n), .wr_n(wr_n), .data_dir(data_dir)
    );

    assign sel_index = board_select[3] ? 2'd3 : board_select[2] ? 2'd2 :
                       board_select[1] ? 2'd1 : 2'd0;

    always_comb
    begin
        data_in = 8'h00;
        if (!rd_n)
            data_in = test_address ? (8'h5A ^ {6'b0, sel_index})
                                   : (board_reg[sel_index] ^ {bus_address, 5'b0});
    end

    always @(posedge clock)
    begin
        if (!prev_wr_n && wr_n && prev_rd_n && board_select != 4'b0)
            board_reg[sel_index] <= data_out; // Latch on the wr_n rising edge
        prev_wr_n <= wr_n;
        prev_rd_n <= rd_n;
    end

    task automatic add_row(input bus_opcode_t op, input logic [2:0] addr,
                           input logic [31:0] param, input logic [2:0] count,
                           input logic twice);
        tab_op.push_back(op);
        tab_addr.push_back(addr);
        tab_param.push_back(param);
        tab_count.push_back(count);
        tab_twice.push_back(twice);
    endtask

    task automatic load_table();
        add_row(OP_WRITE4,   3'd0, 32'h4433_2211, 3'd0, 1'b0);
        add_row(OP_READ4,    3'd0, 32'h0,         3'd4, 1'b0);
        add_row(OP_READ4,    3'd5, 32'h0,         3'd4, 1'b0);
        add_row(OP_ADDRTEST, 3'd2, 32'h0,         3'd4, 1'b0);
        add_row(OP_ADC4,     3'd3, $random(seed), 3'd4, 1'b0);
        add_row(OP_READ4,    3'd7, 32'h0,         3'd4, 1'b1);
        add_row(OP_WRITE4,   3'd1, $random(seed), 3'd0, 1'b0);
        add_row(OP_ADC4,     3'd6, $random(seed), 3'd4, 1'b1);
        add_row(OP_ADDRTEST, 3'd0, 32'h0,         3'd4, 1'b0);
        add_row(OP_READ4,    3'd4, 32'h0,         3'd4, 1'b0);
    endtask

    task automatic pulse_start(input bus_opcode_t op, input logic [2:0] addr,
                               input logic [31:0] param);
        @(posedge clock);
        #1;
        opcode     = op;
        address    = addr;
        param_word = param;
        start      = 1'b1;
        @(posedge clock);
        #1;
        start = 1'b0;
    endtask

    task automatic run_row(input int row);
        pulse_start(tab_op[row], tab_addr[row], tab_param[row]);
        expected_count = tab_count[row];
        if (tab_twice[row])
        begin
            repeat (2) @(posedge clock);
            pulse_start(OP_ADDRTEST, ~tab_addr[row], ~tab_param[row]); // Dropped while busy
        end
        do
        begin
            @(posedge clock);
            #1;
        end
        while (done !== 1'b1);
    endtask

    initial
    begin
        rst            = 1'b1;
        start          = 1'b0;
        opcode         = OP_WRITE4;
        address        = 3'd0;
        param_word     = 32'h0;
        expected_count = 3'd0;
        run_over       = 1'b0;
        load_table();
        repeat (3) @(posedge clock);
        #1;
        rst = 1'b0;
        for (int row = 0; row < tab_op.size(); row++)
            run_row(row);
        repeat (2) @(posedge clock);
        #1;
        run_over = 1'b1;
        repeat (2) @(posedge clock);
        #1;
        assertion_failures = board_bus_top_inst.u_board_bus_sequencer.bus_rules.failures;
        $display("errors: checker %0d, assertions %0d, commands completed %0d",
                 error_count, assertion_failures, done_count);
        if (error_count == 0 && assertion_failures == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(WATCHDOG_CYCLES * 100);
        $display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

endmodule

// ==== verification/board_bus_checker.sv ====
`timescale 1ns/1ps

module board_bus_checker
#(
    parameter int COMMANDS = 10
)
(
    input  logic                       clock,
    input  logic                       rst,
    input  logic                       start,
    input  board_bus_pkg::bus_opcode_t opcode,
    input  logic [2:0]                 address,
    input  logic [31:0]                param_word,
    input  logic                       busy,
    input  logic                       done,
    input  logic [31:0]                response_word,
    input  logic [2:0]                 response_count,
    input  logic [3:0]                 board_select,
    input  logic [2:0]                 bus_address,
    input  logic                       test_address,
    input  logic                       rd_n,
    input  logic                       wr_n,
    input  logic [7:0]                 data_out,
    input  logic                       data_dir,
    input  logic [2:0]                 expected_count,
    input  logic                       run_over,
    output int                         error_count,
    output int                         done_count
);
    import board_bus_pkg::*;

    bus_opcode_t cmd_op;
    logic [2:0]  cmd_address;
    logic [31:0] cmd_param;
    logic        pending;
    logic        closed;
    int          writes_seen;
    logic [7:0]  shadow [4]; // Board registers as seen from the bus
    logic        prev_wr_n;
    logic        prev_rd_n;

    function automatic int select_index(input logic [3:0] sel);
        int index;
        index = -1;
        for (int i = 0; i < 4; i++)
            if (sel == (4'b0001 << i))
                index = i;
        return index;
    endfunction

    // Response byte that board i should have returned
    function automatic logic [7:0] expected_byte(input int board);
        case (cmd_op)
            OP_WRITE4:   return 8'h00;
            OP_ADDRTEST: return 8'h5A ^ 8'(board);
            default:     return shadow[board] ^ {cmd_address, 5'b0};
        endcase
    endfunction

    task automatic note_failure(input string msg);
        $display("at %0t: %s", $time, msg);
        error_count++;
    endtask

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("error at %0t: %s is %h, expected %h", $time, what, got, expected);
            error_count++;
        end
    endtask

    task automatic check_response();
        int writes_expected;
        writes_expected = (cmd_op == OP_WRITE4 || cmd_op == OP_ADC4) ? 4 : 0;
        if (busy)
            note_failure("busy still high in the done cycle");
        compare_value("response_count", 32'(response_count), 32'(expected_count));
        compare_value("write strobes", writes_seen, writes_expected);
        for (int i = 0; i < 4; i++)
            compare_value($sformatf("response byte %0d", i),
                          32'(response_word[i*8 +: 8]), 32'(expected_byte(i)));
    endtask

    always @(posedge clock)
    begin
        int board;
        if (rst)
        begin
            error_count = 0;
            done_count  = 0;
            pending     = 1'b0;
            closed      = 1'b0;
            writes_seen = 0;
            prev_wr_n   = 1'b1;
            prev_rd_n   = 1'b1;
            for (int i = 0; i < 4; i++)
                shadow[i] = 8'h00;
        end
        else
        begin
            board = select_index(board_select);
            if (!busy && (!rd_n || !wr_n || board_select != 4'b0 || data_dir))
                note_failure("bus not idle while busy is low");
            if ((!rd_n || !wr_n) && board < 0)
                note_failure("strobe without exactly one board selected");
            if (test_address !== (!rd_n && !wr_n))
                note_failure("test_address does not match the test strobe");
            if (!wr_n && rd_n && !data_dir)
                note_failure("data_dir low during a write strobe");
            if (!rd_n || !wr_n)
                compare_value("bus_address", 32'(bus_address), 32'(cmd_address));

            // wr_n rising with rd_n high is a board write
            if (!prev_wr_n && wr_n && prev_rd_n)
            begin
                if (board != writes_seen)
                    note_failure("write strobe out of board order");
                else
                begin
                    compare_value($sformatf("data_out for board %0d", board),
                                  32'(data_out), 32'(cmd_param[board*8 +: 8]));
                    shadow[board] = data_out;
                end
                writes_seen++;
            end

            if (start && !busy)
            begin
                if (pending)
                    note_failure("start accepted while a command is still open");
                pending     = 1'b1;
                cmd_op      = opcode;
                cmd_address = address;
                cmd_param   = param_word;
                writes_seen = 0;
            end

            if (done)
            begin
                done_count++;
                if (!pending)
                    note_failure("done without an accepted command");
                else
                    check_response();
                pending = 1'b0;
            end

            if (run_over && !closed)
            begin
                closed = 1'b1;
                if (pending)
                    note_failure("a command never completed");
                if (done_count != COMMANDS)
                    note_failure($sformatf("%0d done pulses for %0d commands",
                                           done_count, COMMANDS));
            end
            prev_wr_n = wr_n;
            prev_rd_n = rd_n;
        end
    end

endmodule

// ==== verification/board_bus_properties.sv ====
`timescale 1ns/1ps

module board_bus_properties
(
    input  logic                                  clock,
    input  logic                                  rst,
    input  board_bus_pkg::seq_state_t             state,
    input  logic [board_bus_pkg::BOARD_COUNT-1:0] board_select,
    input  logic                                  test_address,
    input  logic                                  rd_n,
    input  logic                                  wr_n,
    input  logic                                  data_dir
);
    import board_bus_pkg::*;

    int failures = 0; // Read by the testbench at the end

    // Both strobes low only for the address test
    strobe_pair: assert property (@(posedge clock) disable iff (rst)
        (!rd_n && !wr_n) |-> test_address)
    else
    begin
        $error("rd_n and wr_n low together without test_address");
        failures = failures + 1;
    end

    select_one_hot: assert property (@(posedge clock) disable iff (rst)
        $onehot0(board_select))
    else
    begin
        $error("board_select has more than one bit set");
        failures = failures + 1;
    end

    no_drive_on_read: assert property (@(posedge clock) disable iff (rst)
        !rd_n |-> !data_dir)
    else
    begin
        $error("data_dir high while rd_n is low");
        failures = failures + 1;
    end

    // Strobes only in the two strobe states
    strobe_state: assert property (@(posedge clock) disable iff (rst)
        (!rd_n || !wr_n) |-> (state == S_STROBE || state == S_ADC_READ))
    else
    begin
        $error("strobe low outside a strobe state");
        failures = failures + 1;
    end

endmodule

// ==== logic/board_bus_top.sv ====
`timescale 1ns/1ps

module board_bus_top
#(
    parameter int unsigned CLOCK_FREQUENCY = 27_000_000,
    parameter int unsigned SETTLE_NS       = 750
)
(
    input  logic                                    clock,
    input  logic                                    rst,
    input  logic                                    start,
    input  board_bus_pkg::bus_opcode_t              opcode,
    input  logic [board_bus_pkg::ADDRESS_WIDTH-1:0] address,
    input  logic [31:0]                             param_word,
    output logic                                    busy,
    output logic                                    done,
    output logic [31:0]                             response_word,
    output logic [2:0]                              response_count,
    output logic [board_bus_pkg::BOARD_COUNT-1:0]   board_select,
    output logic [board_bus_pkg::ADDRESS_WIDTH-1:0] bus_address,
    output logic                                    test_address,
    output logic                                    rd_n,
    output logic                                    wr_n,
    output logic [board_bus_pkg::BYTE_WIDTH-1:0]    data_out,
    output logic                                    data_dir,
    input  logic [board_bus_pkg::BYTE_WIDTH-1:0]    data_in
);

    board_cmd_if cmd_bus ();

    // Host side command and response registers
    command_registers u_command_registers
    (
        .clock          (clock),
        .rst            (rst),
        .start          (start),
        .opcode         (opcode),
        .address        (address),
        .param_word     (param_word),
        .busy           (busy),
        .done           (done),
        .response_word  (response_word),
        .response_count (response_count),
        .cmd            (cmd_bus.regs)
    );

    board_bus_sequencer
    #(
        .CLOCK_FREQUENCY (CLOCK_FREQUENCY),
        .SETTLE_NS       (SETTLE_NS)
    )
    u_board_bus_sequencer
    (
        .clock        (clock),
        .rst          (rst),
        .cmd          (cmd_bus.seq),
        .board_select (board_select),
        .bus_address  (bus_address),
        .test_address (test_address),
        .rd_n         (rd_n),
        .wr_n         (wr_n),
        .data_out     (data_out),
        .data_dir     (data_dir),
        .data_in      (data_in)
    );

endmodule

// ==== logic/board_bus_sequencer.sv ====
`timescale 1ns/1ps

module board_bus_sequencer
#(
    parameter int unsigned CLOCK_FREQUENCY = 27_000_000, // Hz
    parameter int unsigned SETTLE_NS       = 750
)
(
    input  logic                                    clock,
    input  logic                                    rst,
    board_cmd_if.seq                                cmd,
    output logic [board_bus_pkg::BOARD_COUNT-1:0]   board_select,
    output logic [board_bus_pkg::ADDRESS_WIDTH-1:0] bus_address,
    output logic                                    test_address,
    output logic                                    rd_n,
    output logic                                    wr_n,
    output logic [board_bus_pkg::BYTE_WIDTH-1:0]    data_out,
    output logic                                    data_dir,
    input  logic [board_bus_pkg::BYTE_WIDTH-1:0]    data_in
);
    import board_bus_pkg::*;

    // Settle time in clock cycles, rounded up
    localparam longint unsigned SETTLE_PRODUCT =
        longint'(CLOCK_FREQUENCY) * longint'(SETTLE_NS);
    localparam int unsigned SETTLE_RAW =
        int'((SETTLE_PRODUCT + 64'd999_999_999) / 64'd1_000_000_000);
    localparam int unsigned SETTLE_CYCLES = (SETTLE_RAW == 0) ? 1 : SETTLE_RAW;
    localparam int          CNT_W         = $clog2(SETTLE_CYCLES + 1);
    localparam logic [CNT_W-1:0] SETTLE_LOAD = CNT_W'(SETTLE_CYCLES - 1);

    seq_state_t                     state;
    logic [CNT_W-1:0]               settle_count;
    logic [$clog2(BOARD_COUNT)-1:0] board_ptr;

    logic write_pass;
    logic read_pass;
    logic last_cycle;

    assign write_pass = (cmd.opcode == OP_WRITE4) || (cmd.opcode == OP_ADC4);
    assign read_pass  = (cmd.opcode == OP_READ4) || (cmd.opcode == OP_ADDRTEST);
    assign last_cycle = (settle_count == '0);

    // Read byte taken on the last strobe cycle
    assign cmd.result_we    = last_cycle &&
                              (((state == S_STROBE) && read_pass) || (state == S_ADC_READ));
    assign cmd.result_index = board_ptr;
    assign cmd.result_byte  = data_in;
    assign cmd.finish       = (state == S_DONE);

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            state        <= S_IDLE;
            settle_count <= '0;
            board_ptr    <= '0;
            board_select <= '0;
            bus_address  <= '0;
            test_address <= 1'b0;
            rd_n         <= 1'b1;
            wr_n         <= 1'b1;
            data_dir     <= 1'b0;
        end
        else
        begin
            if (settle_count != '0)
                settle_count <= settle_count - 1'b1;

            case (state)
                S_IDLE:
                begin
                    board_ptr <= '0;
                    if (cmd.go)
                        state <= S_PRE_DELAY;
                end
                S_PRE_DELAY:
                    state <= S_ASSERT_ADDRESS;
                S_ASSERT_ADDRESS:
                begin
                    board_select <= BOARD_COUNT'(1) << board_ptr; // One board at a time
                    bus_address  <= cmd.address;
                    settle_count <= SETTLE_LOAD;
                    state        <= S_SETTLE;
                end
                S_SETTLE:
                begin
                    if (last_cycle)
                    begin
                        if (write_pass)
                            state <= S_DRIVE_DATA;
                        else
                        begin
                            // Plain read, or both strobes for the address test
                            rd_n         <= 1'b0;
                            wr_n         <= !(cmd.opcode == OP_ADDRTEST);
                            test_address <= (cmd.opcode == OP_ADDRTEST);
                            settle_count <= SETTLE_LOAD;
                            state        <= S_STROBE;
                        end
                    end
                end
                S_DRIVE_DATA:
                begin
                    wr_n         <= 1'b0; // Data is already on the bus
                    settle_count <= SETTLE_LOAD;
                    state        <= S_STROBE;
                end
                S_STROBE:
                begin
                    if (last_cycle)
                    begin
                        rd_n         <= 1'b1;
                        wr_n         <= 1'b1;
                        test_address <= 1'b0;
                        state        <= S_RELEASE_STROBE;
                    end
                end
                S_RELEASE_STROBE:
                begin
                    data_dir <= 1'b0;
                    state    <= S_RELEASE_DATA;
                end
                S_RELEASE_DATA:
                begin
                    // Adc4 reads back the conversion byte on the same board
                    if (cmd.opcode == OP_ADC4)
                    begin
                        rd_n         <= 1'b0;
                        settle_count <= SETTLE_LOAD;
                        state        <= S_ADC_READ;
                    end
                    else
                        state <= S_NEXT_BOARD;
                end
                S_ADC_READ:
                begin
                    if (last_cycle)
                    begin
                        rd_n  <= 1'b1;
                        state <= S_NEXT_BOARD;
                    end
                end
                S_NEXT_BOARD:
                begin
                    board_select <= '0;
                    if (board_ptr == BOARD_COUNT - 1)
                        state <= S_DONE;
                    else
                    begin
                        board_ptr <= board_ptr + 1'b1;
                        state     <= S_PRE_DELAY;
                    end
                end
                S_DONE:
                    state <= S_IDLE;
                default:
                    state <= S_IDLE;
            endcase

            if ((state == S_SETTLE) && last_cycle && write_pass)
                data_dir <= 1'b1; // Drive before the write strobe
        end
    end

    // Write data for the current board
    always_ff @(posedge clock)
    begin
        if ((state == S_SETTLE) && last_cycle && write_pass)
            data_out <= cmd.param_bytes[board_ptr];
    end

endmodule

// ==== logic/command_registers.sv ====
`timescale 1ns/1ps

module command_registers
(
    input  logic                                                   clock,
    input  logic                                                   rst,
    input  logic                                                   start,
    input  board_bus_pkg::bus_opcode_t                             opcode,
    input  logic [board_bus_pkg::ADDRESS_WIDTH-1:0]                address,
    input  logic [board_bus_pkg::BOARD_COUNT*board_bus_pkg::BYTE_WIDTH-1:0] param_word,
    output logic                                                   busy,
    output logic                                                   done,
    output logic [board_bus_pkg::BOARD_COUNT*board_bus_pkg::BYTE_WIDTH-1:0] response_word,
    output logic [2:0]                                             response_count,
    board_cmd_if.regs                                              cmd
);
    import board_bus_pkg::*;

    logic accept;

    assign accept = start && !busy; // Start while busy is dropped

    // Control state
    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            busy           <= 1'b0;
            done           <= 1'b0;
            cmd.go         <= 1'b0;
            response_count <= '0;
        end
        else
        begin
            cmd.go <= accept;
            done   <= cmd.finish;
            if (accept)
            begin
                busy           <= 1'b1;
                response_count <= '0;
            end
            else if (cmd.finish)
                busy <= 1'b0; // Falls together with done
            if (cmd.result_we)
                response_count <= response_count + 3'd1;
        end
    end

    // Command and response payload
    always_ff @(posedge clock)
    begin
        if (accept)
        begin
            cmd.opcode      <= opcode;
            cmd.address     <= address;
            cmd.param_bytes <= param_word;
            response_word   <= '0;
        end
        else if (cmd.result_we)
            response_word[cmd.result_index*BYTE_WIDTH +: BYTE_WIDTH] <= cmd.result_byte;
    end

endmodule

// ==== logic/board_cmd_if.sv ====
`timescale 1ns/1ps

interface board_cmd_if;
    import board_bus_pkg::*;

    // Command towards the sequencer
    logic                                   go;
    bus_opcode_t                            opcode;
    logic [ADDRESS_WIDTH-1:0]               address;
    logic [BOARD_COUNT-1:0][BYTE_WIDTH-1:0] param_bytes; // Byte i for board i

    // Results back to the register block
    logic                           result_we;
    logic [$clog2(BOARD_COUNT)-1:0] result_index;
    logic [BYTE_WIDTH-1:0]          result_byte;
    logic                           finish;

    modport regs
    (
        output go, opcode, address, param_bytes,
        input  result_we, result_index, result_byte, finish
    );

    modport seq
    (
        input  go, opcode, address, param_bytes,
        output result_we, result_index, result_byte, finish
    );

endinterface

// ==== logic/board_bus_pkg.sv ====
package board_bus_pkg;

    localparam int BOARD_COUNT   = 4;
    localparam int BYTE_WIDTH    = 8;
    localparam int ADDRESS_WIDTH = 3;

    // Host command kinds
    typedef enum logic [1:0]
    {
        OP_WRITE4   = 2'd0,
        OP_READ4    = 2'd1,
        OP_ADC4     = 2'd2,
        OP_ADDRTEST = 2'd3
    } bus_opcode_t;

    // One pass per board, S_ADC_READ only for Adc4
    typedef enum logic [3:0]
    {
        S_IDLE,
        S_PRE_DELAY,
        S_ASSERT_ADDRESS,
        S_SETTLE,
        S_DRIVE_DATA,
        S_STROBE,
        S_RELEASE_STROBE,
        S_RELEASE_DATA,
        S_NEXT_BOARD,
        S_ADC_READ,
        S_DONE
    } seq_state_t;

endpackage
